// ==== list.f ====
disp_pkg.sv
message_store.sv
scroll_timer.sv
digit_scanner.sv
seg_decoder.sv
scroll_display_top.sv
display_checker.sv
tb_scroll_display.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_scroll_display -f list.f -o tb_sim \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1
grep -q "RESULT: PASS" sim.log && exit 0 || exit 1

// ==== tb_scroll_display.sv ====
`default_nettype none

module tb_scroll_display import disp_pkg::*; ();

	localparam int DWELL = 3;
	localparam int SCROLL_FRAMES = 2;
	localparam int FRAME_CYCLES = NUM_DIGITS * (DWELL + 1);
	localparam int MARGIN_FRAMES = 40;
	localparam logic [31:0] SEED = 32'h5c314ecb;

	// one row of the stimulus table
	typedef struct packed {
		logic [15:0] idle;
		logic hold;
		logic valid;
		msg_wr_t wr;
	} step_t;

	logic clk;
	logic reset;
	logic hold;
	logic wr_valid;
	msg_wr_t wr_data;
	logic wr_ready;
	disp_out_t disp_out;

	int mismatch_count;
	int other_count;
	int frame_count;
	int skip_count;
	logic wrapped;

	step_t steps [$];
	int idle_total = 0;
	int timeout_cycles = 0;
	int tb_errors = 0;

	scroll_display_top #(
		.DWELL(DWELL),
		.SCROLL_FRAMES(SCROLL_FRAMES)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.disp_out(disp_out)
	);

	display_checker #(
		.DWELL(DWELL),
		.SCROLL_FRAMES(SCROLL_FRAMES)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.hold(hold),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.disp_out(disp_out),
		.mismatch_count(mismatch_count),
		.other_count(other_count),
		.frame_count(frame_count),
		.skip_count(skip_count),
		.wrapped(wrapped)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic add_row(input int idle, input logic h, input logic v, input addr_t a,
		input code_t c);
		step_t s;
		s.idle = 16'(idle);
		s.hold = h;
		s.valid = v;
		s.wr.addr = a;
		s.wr.code = c;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// free scroll from reset, then a frozen index, then resume
		add_row(80, 1'b0, 1'b0, 4'h0, 4'h0);
		add_row(100, 1'b1, 1'b0, 4'h0, 4'h0);
		add_row(40, 1'b0, 1'b0, 4'h0, 4'h0);
		// single writes that arrive while a frame is on the display
		add_row(9, 1'b0, 1'b1, 4'h5, 4'ha);
		add_row(23, 1'b0, 1'b1, 4'h6, 4'hb);
		// back-to-back writes, the later ones at random places
		add_row(0, 1'b0, 1'b1, 4'h7, 4'hc);
		add_row(0, 1'b0, 1'b1, 4'h8, 4'hd);
		add_row(0, 1'b0, 1'b1, 4'h9, 4'he);
		for (int i = 0; i < 6; i++) begin
			add_row(0, 1'b0, 1'b1, addr_t'($urandom), code_t'($urandom));
		end
		add_row(60, 1'b1, 1'b1, 4'h0, 4'h9);
		// long enough for the index to pass 15 and wrap
		add_row(640, 1'b0, 1'b0, 4'h0, 4'h0);
	endtask

	// drive one row; a write keeps valid up until ready was seen before an edge
	task automatic apply_step(input step_t s);
		logic taken;
		hold = s.hold;
		if (s.valid) begin
			wr_valid = 1'b1;
			wr_data = s.wr;
			taken = 1'b0;
			while (!taken) begin
				@(negedge clk);
				taken = wr_ready;
				@(posedge clk);
				#2;
			end
			wr_valid = 1'b0;
		end
		repeat (s.idle) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic note_failure(input string what);
		tb_errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic check_totals();
		if (frame_count < idle_total / FRAME_CYCLES) begin
			note_failure($sformatf("only %0d frames shown", frame_count));
		end
		if (!wrapped) begin
			note_failure("scroll index never wrapped from 15 to 0");
		end
		if (skip_count == 0) begin
			note_failure("hold never froze a scroll step");
		end
	endtask

	initial begin
		reset = 1'b1;
		hold = 1'b0;
		wr_valid = 1'b0;
		wr_data = '0;
		void'($urandom(SEED));
		build_table();
		foreach (steps[i]) begin
			idle_total += int'(steps[i].idle);
		end
		timeout_cycles = idle_total + MARGIN_FRAMES * FRAME_CYCLES;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		foreach (steps[i]) begin
			apply_step(steps[i]);
		end
		// let the last write reach the pins
		repeat (2 * FRAME_CYCLES) @(posedge clk);
		@(negedge clk);
		check_totals();
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count + tb_errors);
		if (mismatch_count == 0 && other_count + tb_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// watchdog sized from the table length plus a margin of frames
	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: run still going after %0d cycles", timeout_cycles);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count + tb_errors + 1);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== display_checker.sv ====
`default_nettype none

module display_checker import disp_pkg::*; #(
	parameter int DWELL = 3,
	parameter int SCROLL_FRAMES = 2
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic wr_valid,
	input msg_wr_t wr_data,
	input logic wr_ready,
	input disp_out_t disp_out,
	output int mismatch_count,
	output int other_count,
	output int frame_count,
	output int skip_count,
	output logic wrapped
);

	localparam anode_t AN_LEFT = 4'b0111;
	// frame start, blank cycle, decoder register, then visible on the pins
	localparam int FIRST_LIT = 4;

	typedef struct packed {
		msg_wr_t wr;
		int seen;
	} pending_t;

	int mismatches = 0;
	int others = 0;
	int frames = 0;
	int skips = 0;
	logic wrap_seen = 1'b0;

	code_t model_mem [MSG_LEN];
	addr_t model_index;
	pending_t pending [$];
	int cycle;
	int run_len;
	anode_t prev_an;
	anode_t next_an;
	logic seen_lit;
	logic hold_d1;
	logic hold_d2;
	logic ready_d1;
	logic accept_d1;

	assign mismatch_count = mismatches;
	assign other_count = others;
	assign frame_count = frames;
	assign skip_count = skips;
	assign wrapped = wrap_seen;

	// usual hex shapes as gfedcba with 1 = lit
	function automatic seg_t expected_seg(code_t c);
		logic [6:0] lit;
		case (c)
			4'h0: lit = 7'h3f;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5b;
			4'h3: lit = 7'h4f;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6d;
			4'h6: lit = 7'h7d;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7f;
			4'h9: lit = 7'h6f;
			4'ha: lit = 7'h77;
			4'hb: lit = 7'h7c;
			4'hc: lit = 7'h39;
			4'hd: lit = 7'h5e;
			4'he: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	task automatic check_value(input string sig, input logic [15:0] want, input logic [15:0] got);
		if (got !== want) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %0h got %0h", $time, sig, want, got);
		end
	endtask

	task automatic report_problem(input string what);
		others++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// sampled on the falling edge, halfway between DUT updates
	always @(negedge clk) begin
		int d;
		addr_t pos;
		logic committed;
		pending_t entry;
		if (reset) begin
			check_value("disp_out.an", 16'(AN_OFF), 16'(disp_out.an));
			check_value("disp_out.seg", 16'(SEG_OFF), 16'(disp_out.seg));
			check_value("wr_ready", 16'(1'b1), 16'(wr_ready));
			for (int i = 0; i < MSG_LEN; i++) begin
				model_mem[i] = code_t'(i);
			end
			model_index = '0;
			pending.delete();
			cycle = 0;
			run_len = 0;
			prev_an = AN_OFF;
			next_an = AN_LEFT;
			seen_lit = 1'b0;
			hold_d1 = 1'b0;
			hold_d2 = 1'b0;
			ready_d1 = 1'b1;
			accept_d1 = 1'b0;
		end else begin
			cycle++;
			if (accept_d1 && wr_ready) begin
				report_problem("wr_ready stayed high after a write was accepted");
			end
			if (wr_valid && wr_ready) begin
				entry.wr = wr_data;
				entry.seen = cycle;
				pending.push_back(entry);
			end
			// blank followed by the leftmost digit marks a new frame
			if (prev_an == AN_OFF && disp_out.an == AN_LEFT) begin
				frames++;
				committed = 1'b0;
				// only writes accepted before the frame start edge land in this frame
				while (pending.size() > 0 && pending[0].seen <= cycle - 3) begin
					entry = pending.pop_front();
					model_mem[entry.wr.addr] = entry.wr.code;
					committed = 1'b1;
				end
				if (committed && !ready_d1) begin
					report_problem("wr_ready did not return after the write committed");
				end
				if (frames % SCROLL_FRAMES == 0) begin
					// hold was sampled by the DUT two cycles before this point
					if (hold_d2) begin
						skips++;
					end else begin
						if (model_index == addr_t'(MSG_LEN - 1)) begin
							wrap_seen = 1'b1;
						end
						model_index = model_index + addr_t'(1);
					end
				end
			end
			if (disp_out.an != AN_OFF) begin
				if (!$onehot(~disp_out.an)) begin
					report_problem($sformatf("more than one anode lit, an=%b", disp_out.an));
				end else begin
					d = 0;
					for (int b = 0; b < NUM_DIGITS; b++) begin
						if (!disp_out.an[b]) begin
							d = b;
						end
					end
					pos = model_index + addr_t'(NUM_DIGITS - 1 - d);
					check_value($sformatf("disp_out.seg[digit %0d]", d),
						16'(expected_seg(model_mem[pos])), 16'(disp_out.seg));
				end
			end
			// slot shape: one blank cycle, then DWELL lit cycles, digits left to right
			if (disp_out.an != prev_an) begin
				if (prev_an == AN_OFF) begin
					if (!seen_lit && (disp_out.an != AN_LEFT || cycle != FIRST_LIT)) begin
						report_problem($sformatf("first digit an=%b lit at cycle %0d",
							disp_out.an, cycle));
					end
					if (seen_lit && run_len != 1) begin
						report_problem($sformatf("blank gap of %0d cycles", run_len));
					end
					if (seen_lit && disp_out.an != next_an) begin
						report_problem($sformatf("digit order broken, an=%b", disp_out.an));
					end
					next_an = {disp_out.an[0], disp_out.an[NUM_DIGITS-1:1]};
					seen_lit = 1'b1;
				end else begin
					if (disp_out.an != AN_OFF) begin
						report_problem("digit changed without a blank cycle");
					end
					if (run_len != DWELL) begin
						report_problem($sformatf("digit lit for %0d cycles", run_len));
					end
				end
				run_len = 1;
			end else begin
				run_len++;
			end
			prev_an = disp_out.an;
			hold_d2 = hold_d1;
			hold_d1 = hold;
			ready_d1 = wr_ready;
			accept_d1 = wr_valid && wr_ready;
		end
	end

endmodule

`default_nettype wire

// ==== scroll_display_top.sv ====
`default_nettype none

module scroll_display_top import disp_pkg::*; #(
	parameter int DWELL = 3,
	parameter int SCROLL_FRAMES = 2
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic wr_valid,
	input msg_wr_t wr_data,
	output logic wr_ready,
	output disp_out_t disp_out
);

	logic frame_start;
	addr_t win_index;
	window_t window;
	code_t cur_code;
	anode_t cur_an;

	message_store u_store (
		.clk(clk),
		.reset(reset),
		.wr_valid(wr_valid),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.frame_start(frame_start),
		.win_index(win_index),
		.window(window)
	);

	scroll_timer #(
		.SCROLL_FRAMES(SCROLL_FRAMES)
	) u_timer (
		.clk(clk),
		.reset(reset),
		.frame_start(frame_start),
		.hold(hold),
		.win_index(win_index)
	);

	digit_scanner #(
		.DWELL(DWELL)
	) u_scanner (
		.clk(clk),
		.reset(reset),
		.window(window),
		.frame_start(frame_start),
		.cur_code(cur_code),
		.cur_an(cur_an)
	);

	seg_decoder u_decoder (
		.clk(clk),
		.reset(reset),
		.cur_code(cur_code),
		.cur_an(cur_an),
		.disp_out(disp_out)
	);

endmodule

`default_nettype wire

// ==== seg_decoder.sv ====
`default_nettype none

module seg_decoder import disp_pkg::*; (
	input logic clk,
	input logic reset,
	input code_t cur_code,
	input anode_t cur_an,
	output disp_out_t disp_out
);

	seg_t seg_pattern;

	// gfedcba, a segment is on when its bit is 0
	always_comb begin
		case (cur_code)
			4'h0: seg_pattern = 7'h40;
			4'h1: seg_pattern = 7'h79;
			4'h2: seg_pattern = 7'h24;
			4'h3: seg_pattern = 7'h30;
			4'h4: seg_pattern = 7'h19;
			4'h5: seg_pattern = 7'h12;
			4'h6: seg_pattern = 7'h02;
			4'h7: seg_pattern = 7'h78;
			4'h8: seg_pattern = 7'h00;
			4'h9: seg_pattern = 7'h10;
			4'ha: seg_pattern = 7'h08;
			4'hb: seg_pattern = 7'h03;
			4'hc: seg_pattern = 7'h46;
			4'hd: seg_pattern = 7'h21;
			4'he: seg_pattern = 7'h06;
			default: seg_pattern = 7'h0e;
		endcase
	end

	// anode goes through the same register so both pins switch together
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			disp_out <= '{an: AN_OFF, seg: SEG_OFF};
		end else begin
			disp_out <= '{an: cur_an, seg: seg_pattern};
		end
	end

endmodule

`default_nettype wire

// ==== digit_scanner.sv ====
`default_nettype none

module digit_scanner import disp_pkg::*; #(
	parameter int DWELL = 3
) (
	input logic clk,
	input logic reset,
	input window_t window,
	output logic frame_start,
	output code_t cur_code,
	output anode_t cur_an
);

	localparam int CNT_W = $clog2(DWELL + 1);
	localparam int SLOT_W = $clog2(NUM_DIGITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DWELL);
	localparam logic [SLOT_W-1:0] SLOT_FIRST = SLOT_W'(NUM_DIGITS - 1);

	// slot and cnt describe the cycle that the output registers load next.
	// cnt 0 is the blank cycle, 1..DWELL light the digit
	logic [SLOT_W-1:0] slot;
	logic [CNT_W-1:0] cnt;

	// slot that the outputs currently show
	logic [SLOT_W-1:0] cur_slot;
	logic blank_next;

	assign blank_next = (cnt == '0);

	// leftmost digit first, so the slot counts down and wraps to 3
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			slot <= SLOT_FIRST;
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
			slot <= slot - SLOT_W'(1);
		end else begin
			cnt <= cnt + CNT_W'(1);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			frame_start <= 1'b0;
			cur_an <= AN_OFF;
			cur_slot <= SLOT_FIRST;
		end else begin
			// pulse in the blank cycle ahead of digit 3
			frame_start <= blank_next && (slot == SLOT_FIRST);
			if (blank_next) begin
				cur_an <= AN_OFF;
			end else begin
				cur_an <= ~(anode_t'(1) << slot);
			end
			cur_slot <= slot;
		end
	end

	// selected during the blank cycle; the window for a new frame lands on
	// the edge that ends it, so digit 3 already sees the new contents
	assign cur_code = window[cur_slot];

	// frame start sits in the blank cycle just ahead of the leftmost digit
	a_frame_start_blank: assert property (
		@(posedge clk) disable iff (reset)
		frame_start |=> ($past(cur_an) == AN_OFF && cur_an == ~(anode_t'(1) << SLOT_FIRST))
	);

	// a digit only lights after a cycle with everything dark
	a_blank_before_lit: assert property (
		@(posedge clk) disable iff (reset)
		(cur_an != AN_OFF && $changed(cur_an)) |-> ($past(cur_an) == AN_OFF)
	);

endmodule

`default_nettype wire

// ==== scroll_timer.sv ====
`default_nettype none

module scroll_timer import disp_pkg::*; #(
	parameter int SCROLL_FRAMES = 2
) (
	input logic clk,
	input logic reset,
	input logic frame_start,
	input logic hold,
	output addr_t win_index
);

	localparam int CNT_W = (SCROLL_FRAMES > 1) ? $clog2(SCROLL_FRAMES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCROLL_FRAMES - 1);

	logic [CNT_W-1:0] frame_cnt;
	addr_t index_q;
	logic wrap;
	logic step;

	assign wrap = (frame_cnt == CNT_LAST);

	// hold only skips the step, the frame count keeps going
	assign step = frame_start && wrap && !hold;

	// the stepped index is already presented during the frame start cycle,
	// so the window captured on that edge uses it
	assign win_index = index_q + addr_t'(step);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			frame_cnt <= '0;
			index_q <= '0;
		end else if (frame_start) begin
			if (wrap) begin
				frame_cnt <= '0;
			end else begin
				frame_cnt <= frame_cnt + CNT_W'(1);
			end
			index_q <= win_index;
		end
	end

endmodule

`default_nettype wire

// ==== message_store.sv ====
`default_nettype none

module message_store import disp_pkg::*; (
	input logic clk,
	input logic reset,
	input logic wr_valid,
	input msg_wr_t wr_data,
	output logic wr_ready,
	input logic frame_start,
	input addr_t win_index,
	output window_t window
);

	code_t mem [MSG_LEN];

	// one write waits here until the next frame start
	logic pend_valid;
	msg_wr_t pend;

	addr_t rd_addr [NUM_DIGITS];
	window_t next_window;

	assign wr_ready = ~pend_valid;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pend_valid <= 1'b0;
		end else if (wr_valid && wr_ready) begin
			pend_valid <= 1'b1;
		end else if (frame_start) begin
			pend_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_valid && wr_ready) begin
			pend <= wr_data;
		end
	end

	// element d shows position win_index + (3 - d), so digit 3 gets win_index.
	// the write that commits on this frame start is forwarded into the window
	always_comb begin
		for (int d = 0; d < NUM_DIGITS; d++) begin
			rd_addr[d] = win_index + addr_t'(NUM_DIGITS - 1 - d);
			if (pend_valid && pend.addr == rd_addr[d]) begin
				next_window[d] = pend.code;
			end else begin
				next_window[d] = mem[rd_addr[d]];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < MSG_LEN; i++) begin
				mem[i] <= reset_code(addr_t'(i));
			end
			for (int d = 0; d < NUM_DIGITS; d++) begin
				window[d] <= reset_code(addr_t'(NUM_DIGITS - 1 - d));
			end
		end else if (frame_start) begin
			if (pend_valid) begin
				mem[pend.addr] <= pend.code;
			end
			// window only moves here, so a frame never mixes two contents
			window <= next_window;
		end
	end

	// a stalled write keeps its payload until it is taken
	a_wr_data_held: assert property (
		@(posedge clk) disable iff (reset)
		(wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_data))
	);

	// commit and window capture expect a single-cycle frame start
	a_frame_start_pulse: assert property (
		@(posedge clk) disable iff (reset)
		frame_start |=> !frame_start
	);

endmodule

`default_nettype wire

// ==== disp_pkg.sv ====
`default_nettype none

package disp_pkg;

	localparam int NUM_DIGITS = 4;
	localparam int MSG_LEN = 16;

	// one hex character
	typedef logic [3:0] code_t;

	// position in the message, wraps modulo 16
	typedef logic [3:0] addr_t;

	// segments g..a, active low
	typedef logic [6:0] seg_t;

	// one bit per digit, active low, bit 3 is the leftmost digit
	typedef logic [NUM_DIGITS-1:0] anode_t;

	// four visible codes, element 3 is the leftmost digit
	typedef code_t [NUM_DIGITS-1:0] window_t;

	// payload of one message write
	typedef struct packed {
		addr_t addr;
		code_t code;
	} msg_wr_t;

	// display pins
	typedef struct packed {
		anode_t an;
		seg_t seg;
	} disp_out_t;

	localparam anode_t AN_OFF = '1;
	localparam seg_t SEG_OFF = '1;

	// after reset every position holds its own address
	function automatic code_t reset_code(addr_t a);
		return code_t'(a);
	endfunction

endpackage

`default_nettype wire
